// ==== rtl/fetch_cfg.svh ====
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

//////////////////////////////
// front end sizing
//////////////////////////////

// address and instruction width
`define FETCH_XLEN 32

// direct-mapped cache, 32 lines of 64 bits
`define FETCH_INDEX_BITS 5
`define FETCH_LINES 32

// tag is address bits 15..8
`define FETCH_TAG_BITS 8

// pc after reset
`define FETCH_RESET_PC 32'h0000_0000

// bus transaction tag, zero means no tag
`define FETCH_MEM_TAG_BITS 4

`endif

// ==== rtl/fetch_pkg.sv ====
`include "fetch_cfg.svh"

package fetch_pkg;

	//////////////////////////////
	// memory bus
	//////////////////////////////

	// bus command, only none and load are issued by fetch
	typedef enum logic [1:0] {
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} mem_command_t;

	// request / reply tag
	typedef logic [`FETCH_MEM_TAG_BITS-1:0] mem_tag_t;

	//////////////////////////////
	// cache
	//////////////////////////////

	// line index into the data, tag and valid arrays
	typedef logic [`FETCH_INDEX_BITS-1:0] cache_index_t;

	// address tag stored per line
	typedef logic [`FETCH_TAG_BITS-1:0] cache_tag_t;

	// one line, two instructions
	// lower half is the word with address bit 2 clear
	typedef logic [2*`FETCH_XLEN-1:0] cache_line_t;

endpackage

// ==== rtl/icache_mem.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module icache_mem import fetch_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	// fill port
	input  logic         wr_en,
	input  cache_index_t wr_index,
	input  cache_tag_t   wr_tag,
	input  cache_line_t  wr_data,
	// lookup port
	input  cache_index_t rd_index,
	input  cache_tag_t   rd_tag,
	output cache_line_t  rd_data,
	output logic         rd_hit
);

	//////////////////////////////
	// storage
	//////////////////////////////

	// line data and tags
	cache_line_t data_mem [`FETCH_LINES];
	cache_tag_t  tag_mem  [`FETCH_LINES];

	// one valid bit per line
	logic [`FETCH_LINES-1:0] valid_bits;

	//////////////////////////////
	// lookup
	//////////////////////////////

	// combinational read of the indexed line
	assign rd_data = data_mem[rd_index];

	// hit needs a valid entry and a matching tag
	assign rd_hit = valid_bits[rd_index] && (tag_mem[rd_index] == rd_tag);

	//////////////////////////////
	// fill
	//////////////////////////////

	// valid bits are the only control state here
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_bits <= '0;
		end else if (wr_en) begin
			valid_bits[wr_index] <= 1'b1;
		end
	end

	// data and tag written together, visible after the edge
	always_ff @(posedge clock) begin
		if (wr_en) begin
			data_mem[wr_index] <= wr_data;
			tag_mem[wr_index]  <= wr_tag;
		end
	end

endmodule

// ==== rtl/icache_ctrl.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module icache_ctrl import fetch_pkg::*; (
	input  logic                   clock,
	input  logic                   reset,
	// fetch side
	input  logic [`FETCH_XLEN-1:0] fetch_addr,
	output logic [`FETCH_XLEN-1:0] inst,
	output logic                   inst_valid,
	// cache memory lookup
	output cache_index_t           rd_index,
	output cache_tag_t             rd_tag,
	input  cache_line_t            rd_data,
	input  logic                   rd_hit,
	// cache memory fill
	output logic                   wr_en,
	output cache_index_t           wr_index,
	output cache_tag_t             wr_tag,
	// memory bus
	output mem_command_t           mem_command,
	output logic [`FETCH_XLEN-1:0] mem_addr,
	input  mem_tag_t               mem_response,
	input  mem_tag_t               mem_tag
);

	// byte offset inside a 64-bit line
	localparam int OFFSET_BITS = 3;
	// tag starts right above the index
	localparam int TAG_LSB = OFFSET_BITS + `FETCH_INDEX_BITS;

	//////////////////////////////
	// address split and hit
	//////////////////////////////

	cache_index_t cur_index;
	cache_tag_t   cur_tag;
	logic         word_sel;

	assign cur_index = fetch_addr[OFFSET_BITS +: `FETCH_INDEX_BITS];
	assign cur_tag   = fetch_addr[TAG_LSB +: `FETCH_TAG_BITS];
	// bit 2 picks the upper instruction
	assign word_sel  = fetch_addr[OFFSET_BITS-1];

	// lookup always follows the current fetch address
	assign rd_index = cur_index;
	assign rd_tag   = cur_tag;

	assign inst = word_sel ? rd_data[2*`FETCH_XLEN-1:`FETCH_XLEN]
	                       : rd_data[`FETCH_XLEN-1:0];
	assign inst_valid = rd_hit;

	//////////////////////////////
	// miss tracking
	//////////////////////////////

	// tag of the load in flight, zero when idle
	mem_tag_t     pending_tag;
	// where the returning line goes
	cache_index_t miss_index;
	cache_tag_t   miss_tag;
	// low for one cycle after reset, holds off the first request
	logic         started;

	logic outstanding;
	logic issue;
	logic accepted;
	logic fill;

	assign outstanding = (pending_tag != '0);

	// one miss at a time
	assign issue = started && !rd_hit && !outstanding;

	// nonzero response names the tag, zero means retry next cycle
	assign accepted = issue && (mem_response != '0);

	// reply for the held tag, even if fetch has moved on
	assign fill = outstanding && (mem_tag == pending_tag);

	assign mem_command = issue ? bus_load : bus_none;
	// line aligned request
	assign mem_addr = {fetch_addr[`FETCH_XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

	// fill write, data comes straight off the bus
	assign wr_en    = fill;
	assign wr_index = miss_index;
	assign wr_tag   = miss_tag;

	always_ff @(posedge clock) begin
		if (reset) begin
			pending_tag <= '0;
			started     <= 1'b0;
		end else begin
			started <= 1'b1;
			if (fill) begin
				// line written this edge, free for the next miss
				pending_tag <= '0;
			end else if (accepted) begin
				pending_tag <= mem_response;
			end
		end
	end

	// miss address captured with the accepted request
	always_ff @(posedge clock) begin
		if (accepted) begin
			miss_index <= cur_index;
			miss_tag   <= cur_tag;
		end
	end

endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_stage (
	input  logic                   clock,
	input  logic                   reset,
	// back pressure and redirect from the commit side
	input  logic                   stall,
	input  logic                   redirect,
	input  logic [`FETCH_XLEN-1:0] redirect_pc,
	// instruction cache
	input  logic [`FETCH_XLEN-1:0] inst,
	input  logic                   inst_valid,
	output logic [`FETCH_XLEN-1:0] fetch_addr,
	// fetch packet
	output logic                   fetch_valid,
	output logic [`FETCH_XLEN-1:0] fetch_pc,
	output logic [`FETCH_XLEN-1:0] fetch_inst
);

	//////////////////////////////
	// program counter
	//////////////////////////////

	logic [`FETCH_XLEN-1:0] pc;
	logic                   advance;

	// cache is looked up with the current pc every cycle
	assign fetch_addr = pc;

	// take the instruction only on a hit with no stall or redirect
	assign advance = inst_valid && !stall && !redirect;

	// redirect beats stall, stall beats advance
	always_ff @(posedge clock) begin
		if (reset) begin
			pc          <= `FETCH_RESET_PC;
			fetch_valid <= 1'b0;
		end else if (redirect) begin
			pc          <= redirect_pc;
			fetch_valid <= 1'b0;
		end else if (advance) begin
			pc          <= pc + `FETCH_XLEN'd4;
			fetch_valid <= 1'b1;
		end else begin
			// stall or miss, pc holds
			fetch_valid <= 1'b0;
		end
	end

	//////////////////////////////
	// packet payload
	//////////////////////////////

	// loaded in the same edge as the pc step
	always_ff @(posedge clock) begin
		if (advance) begin
			fetch_pc   <= pc;
			fetch_inst <= inst;
		end
	end

endmodule

// ==== rtl/fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_top import fetch_pkg::*; (
	input  logic                   clock,
	input  logic                   reset,
	// commit side controls
	input  logic                   stall,
	input  logic                   redirect,
	input  logic [`FETCH_XLEN-1:0] redirect_pc,
	// memory bus
	input  mem_tag_t               mem_response,
	input  mem_tag_t               mem_tag,
	input  cache_line_t            mem_data,
	output mem_command_t           mem_command,
	output logic [`FETCH_XLEN-1:0] mem_addr,
	// fetch packet
	output logic                   fetch_valid,
	output logic [`FETCH_XLEN-1:0] fetch_pc,
	output logic [`FETCH_XLEN-1:0] fetch_inst
);

	// fetch to controller
	logic [`FETCH_XLEN-1:0] fetch_addr;
	logic [`FETCH_XLEN-1:0] inst;
	logic                   inst_valid;

	// controller to cache memory
	cache_index_t rd_index;
	cache_tag_t   rd_tag;
	cache_line_t  rd_data;
	logic         rd_hit;
	logic         wr_en;
	cache_index_t wr_index;
	cache_tag_t   wr_tag;

	//////////////////////////////
	// pc and packet register
	//////////////////////////////

	fetch_stage fetch_stage_0 (
		.clock       (clock),
		.reset       (reset),
		.stall       (stall),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.inst        (inst),
		.inst_valid  (inst_valid),
		.fetch_addr  (fetch_addr),
		.fetch_valid (fetch_valid),
		.fetch_pc    (fetch_pc),
		.fetch_inst  (fetch_inst)
	);

	//////////////////////////////
	// cache controller, owns the bus
	//////////////////////////////

	icache_ctrl icache_ctrl_0 (
		.clock        (clock),
		.reset        (reset),
		.fetch_addr   (fetch_addr),
		.inst         (inst),
		.inst_valid   (inst_valid),
		.rd_index     (rd_index),
		.rd_tag       (rd_tag),
		.rd_data      (rd_data),
		.rd_hit       (rd_hit),
		.wr_en        (wr_en),
		.wr_index     (wr_index),
		.wr_tag       (wr_tag),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.mem_response (mem_response),
		.mem_tag      (mem_tag)
	);

	// fill data taken directly from the bus
	icache_mem icache_mem_0 (
		.clock    (clock),
		.reset    (reset),
		.wr_en    (wr_en),
		.wr_index (wr_index),
		.wr_tag   (wr_tag),
		.wr_data  (mem_data),
		.rd_index (rd_index),
		.rd_tag   (rd_tag),
		.rd_data  (rd_data),
		.rd_hit   (rd_hit)
	);

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module mem_model import fetch_pkg::*; (
	input  logic                   clock,
	input  logic                   reset,
	input  mem_command_t           mem_command,
	input  logic [`FETCH_XLEN-1:0] mem_addr,
	output mem_tag_t               mem_response,
	output mem_tag_t               mem_tag,
	output cache_line_t            mem_data
);

	// cycles from accept to reply
	localparam int LATENCY = 4;

	mem_tag_t               next_tag;
	// delay line of accepted loads, tag zero is an empty slot
	mem_tag_t               pipe_tag  [LATENCY];
	logic [`FETCH_XLEN-1:0] pipe_addr [LATENCY];

	// upper half A5C3, lower half the low address bits
	function automatic logic [`FETCH_XLEN-1:0] word_at(input logic [`FETCH_XLEN-1:0] a);
		return {16'hA5C3, a[15:0]};
	endfunction

	// every load accepted in its own cycle
	assign mem_response = (mem_command == bus_load) ? next_tag : '0;

	// reply leaves the last stage, upper word is address + 4
	assign mem_tag  = pipe_tag[LATENCY-1];
	assign mem_data = {word_at(pipe_addr[LATENCY-1] + 4), word_at(pipe_addr[LATENCY-1])};

	always @(posedge clock) begin
		if (reset) begin
			next_tag <= 1;
			for (int i = 0; i < LATENCY; i++) begin
				pipe_tag[i]  <= '0;
				pipe_addr[i] <= '0;
			end
		end else begin
			// tags run 1..15, zero never handed out
			if (mem_command == bus_load) begin
				next_tag <= (next_tag == 15) ? mem_tag_t'(1) : next_tag + 1'b1;
			end
			pipe_tag[0]  <= (mem_command == bus_load) ? next_tag : '0;
			pipe_addr[0] <= mem_addr;
			for (int i = 1; i < LATENCY; i++) begin
				pipe_tag[i]  <= pipe_tag[i-1];
				pipe_addr[i] <= pipe_addr[i-1];
			end
		end
	end

endmodule

// ==== tb/fetch_top_tb.sv ====
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_top_tb import fetch_pkg::*; ();

	// cycles allowed for any single wait
	localparam int WAIT_LIMIT = 200;

	logic                   clock;
	logic                   reset;
	logic                   stall;
	logic                   redirect;
	logic [`FETCH_XLEN-1:0] redirect_pc;
	mem_tag_t               mem_response;
	mem_tag_t               mem_tag;
	cache_line_t            mem_data;
	mem_command_t           mem_command;
	logic [`FETCH_XLEN-1:0] mem_addr;
	logic                   fetch_valid;
	logic [`FETCH_XLEN-1:0] fetch_pc;
	logic [`FETCH_XLEN-1:0] fetch_inst;

	// scoreboard state
	logic [`FETCH_XLEN-1:0] expected_pc;
	logic [`FETCH_XLEN-1:0] last_pc;
	int                     errors;
	int                     packet_count;
	int                     load_count;
	integer                 seed;
	string                  test_name;

	fetch_top DUT (
		.clock        (clock),
		.reset        (reset),
		.stall        (stall),
		.redirect     (redirect),
		.redirect_pc  (redirect_pc),
		.mem_response (mem_response),
		.mem_tag      (mem_tag),
		.mem_data     (mem_data),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.fetch_valid  (fetch_valid),
		.fetch_pc     (fetch_pc),
		.fetch_inst   (fetch_inst)
	);

	mem_model mem_model_0 (
		.clock        (clock),
		.reset        (reset),
		.mem_command  (mem_command),
		.mem_addr     (mem_addr),
		.mem_response (mem_response),
		.mem_tag      (mem_tag),
		.mem_data     (mem_data)
	);

	// 100 ns period
	always #50 clock = ~clock;

	//////////////////////////////
	// helpers
	//////////////////////////////

	// instruction expected at byte address a
	function automatic logic [`FETCH_XLEN-1:0] rule_inst(input logic [`FETCH_XLEN-1:0] a);
		return {16'hA5C3, a[15:0]};
	endfunction

	// compare one packet against the running pc
	task automatic check_packet();
		if (fetch_pc !== expected_pc) begin
			$display("[FAIL] %s pc: expected %h, actual %h", test_name, expected_pc, fetch_pc);
			errors++;
		end
		if (fetch_inst !== rule_inst(expected_pc)) begin
			$display("[FAIL] %s inst: expected %h, actual %h", test_name,
				rule_inst(expected_pc), fetch_inst);
			errors++;
		end
		last_pc = fetch_pc;
		// resync so one slip is reported once
		expected_pc = fetch_pc + 4;
		packet_count++;
	endtask

	// one cycle with outputs sampled at the falling edge before new inputs go out
	task automatic next_cycle();
		logic [`FETCH_XLEN-1:0] line_addr;
		@(negedge clock);
		// stall or redirect seen at the last edge must block the packet
		if (fetch_valid && (stall || redirect)) begin
			$display("%s: packet valid at %h while stall or redirect was applied",
				test_name, fetch_pc);
			errors++;
		end else if (fetch_valid && !reset) begin
			check_packet();
		end
		// bus monitor
		// a load asks for the aligned line of the pc still to be fetched
		if (!reset && mem_command == bus_load) begin
			load_count++;
			line_addr = {expected_pc[`FETCH_XLEN-1:3], 3'b000};
			if (mem_addr !== line_addr) begin
				$display("[FAIL] %s mem_addr: expected %h, actual %h", test_name,
					line_addr, mem_addr);
				errors++;
			end
		end
	endtask

	task automatic wait_packets(input int n);
		int target;
		int cycles;
		target = packet_count + n;
		cycles = 0;
		while (packet_count < target && cycles < WAIT_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (packet_count < target) begin
			$display("%s: timed out waiting for %0d fetch packets", test_name, n);
			errors++;
		end
	endtask

	// one cycle redirect strobe
	task automatic apply_redirect(input logic [`FETCH_XLEN-1:0] target);
		next_cycle();
		redirect    = 1'b1;
		redirect_pc = target;
		expected_pc = target;
		next_cycle();
		redirect = 1'b0;
	endtask

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic reset_state();
		test_name = "reset_state";
		// three reset edges with the last sample in the cycle after them
		for (int i = 0; i < 3; i++) begin
			next_cycle();
			if (fetch_valid !== 1'b0) begin
				$display("[FAIL] %s fetch_valid: expected 0, actual %b", test_name, fetch_valid);
				errors++;
			end
			if (mem_command !== bus_none) begin
				$display("[FAIL] %s mem_command: expected %0d, actual %0d", test_name,
					bus_none, mem_command);
				errors++;
			end
		end
		reset = 1'b0;
		next_cycle();
		if (fetch_valid !== 1'b0) begin
			$display("[FAIL] %s fetch_valid: expected 0, actual %b", test_name, fetch_valid);
			errors++;
		end
	endtask

	task automatic sequential_fetch();
		test_name = "sequential_fetch";
		wait_packets(16);
	endtask

	// lines 0..0x3f are resident so no bus traffic is expected
	task automatic hit_after_fill();
		int loads_before;
		test_name = "hit_after_fill";
		apply_redirect(32'h0);
		loads_before = load_count;
		wait_packets(16);
		if (load_count != loads_before) begin
			$display("[FAIL] %s bus loads: expected %0d, actual %0d", test_name,
				loads_before, load_count);
			errors++;
		end
	endtask

	task automatic redirect_stream();
		test_name = "redirect";
		wait_packets(5);
		apply_redirect(32'h100);
		wait_packets(1);
		if (last_pc !== 32'h100) begin
			$display("[FAIL] %s first pc: expected %h, actual %h", test_name, 32'h100, last_pc);
			errors++;
		end
		wait_packets(8);
	endtask

	// random stall lengths between packet bursts
	task automatic stall_hold();
		int len;
		test_name = "stall_hold";
		for (int round = 0; round < 6; round++) begin
			wait_packets(2);
			len = 1 + ({$random(seed)} % 6);
			stall = 1'b1;
			for (int i = 0; i < len; i++) begin
				next_cycle();
			end
			stall = 1'b0;
		end
		wait_packets(4);
	endtask

	// 0x0 shares index 0 with 0x100 but has another tag
	task automatic tag_conflict();
		int loads_before;
		test_name = "tag_conflict";
		apply_redirect(32'h0);
		loads_before = load_count;
		wait_packets(4);
		if (load_count == loads_before) begin
			$display("%s: no bus load seen after the conflicting redirect", test_name);
			errors++;
		end
	endtask

	//////////////////////////////
	// sequence
	//////////////////////////////

	initial begin
		clock        = 1'b0;
		reset        = 1'b1;
		stall        = 1'b0;
		redirect     = 1'b0;
		redirect_pc  = '0;
		expected_pc  = `FETCH_RESET_PC;
		last_pc      = '0;
		errors       = 0;
		packet_count = 0;
		load_count   = 0;
		seed         = 78173;
		test_name    = "init";

		reset_state();
		sequential_fetch();
		hit_after_fill();
		redirect_stream();
		stall_hold();
		tag_conflict();

		$display("errors %0d  packets %0d  bus loads %0d", errors, packet_count, load_count);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/fetch_pkg.sv
rtl/icache_mem.sv
rtl/icache_ctrl.sv
rtl/fetch_stage.sv
rtl/fetch_top.sv
tb/mem_model.sv
tb/fetch_top_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fetch_pkg.sv
      - rtl/icache_mem.sv
      - rtl/icache_ctrl.sv
      - rtl/fetch_stage.sv
      - rtl/fetch_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/mem_model.sv
      - tb/fetch_top_tb.sv
